// ==== design/queue_pkg.sv ====
/* Sizes and shared types of the packet queue. The reset page layout
   assumes num_pages >= 2*num_queues and packets no longer than 6 words. */
`default_nettype none

package queue_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizes

    localparam int data_bytes      = 8;
    localparam int words_per_page  = 4;
    localparam int num_pages       = 16;
    localparam int num_queues      = 4;
    localparam int queues_per_port = 2;
    localparam int num_ports       = 2;

    //////////////////////////////////////////////////////////////////////
    // Vector types

    typedef logic [data_bytes*8-1:0]                      data_t;
    typedef logic [data_bytes-1:0]                        keep_t;
    // 0 means a full word, n means the lowest n bytes
    typedef logic [$clog2(data_bytes)-1:0]                keep_code_t;
    typedef logic [$clog2(num_pages)-1:0]                 page_t;
    typedef logic [$clog2(words_per_page)-1:0]            offset_t;
    typedef logic [$clog2(num_pages*words_per_page)-1:0]  mem_addr_t;
    typedef logic [$clog2(num_queues)-1:0]                queue_id_t;
    typedef logic [$clog2(num_ports)-1:0]                 port_t;
    typedef logic [$clog2(num_pages*words_per_page):0]    count_t;
    typedef logic [$clog2(data_bytes):0]                  byte_count_t;

    //////////////////////////////////////////////////////////////////////
    // Structs

    typedef struct packed {
        data_t     data;
        keep_t     keep;
        logic      last;
        queue_id_t queue_id;
    } in_word_t;

    // Tail record of one queue
    typedef struct packed {
        page_t   cur_page;
        page_t   next_page;
        offset_t tail_offset;
    } enq_meta_t;

    typedef struct packed {
        in_word_t  word;
        enq_meta_t meta;
    } enq_word_t;

    typedef struct packed {
        queue_id_t queue_id;
        page_t     head_page;
        offset_t   head_offset;
    } head_read_t;

    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
        port_t port;
    } out_word_t;

    typedef struct packed {
        queue_id_t   queue_id;
        byte_count_t byte_count;
        logic        last;
    } deq_note_t;

endpackage

`default_nettype wire

// ==== design/page_allocator.sv ====
/* Free page list and page link table. Running out of pages is not detected;
   at most num_pages - 2*num_queues pages are ever free at once. */
`timescale 1ns/1ps
`default_nettype none

module page_allocator (
    input  wire                    packet_in,
    input  wire                    rst,
    input  wire                    alloc_pop,
    output queue_pkg::page_t       alloc_page,
    input  wire                    page_free,
    input  wire queue_pkg::page_t  page_free_num,
    input  wire                    link_wr,
    input  wire queue_pkg::page_t  link_page,
    input  wire queue_pkg::page_t  link_next,
    input  wire queue_pkg::page_t  link_rd_page,
    output queue_pkg::page_t       link_of
);

    import queue_pkg::*;

    // Circular list, one entry per page so it never overflows
    page_t free_list [num_pages];
    page_t rd_ptr;
    page_t wr_ptr;

    // Next page of the same queue, indexed by page
    page_t link_table [num_pages];

    // Head of the list is always valid
    assign alloc_page = free_list[rd_ptr];
    assign link_of    = link_table[link_rd_page];

    always_ff @(posedge packet_in) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= page_t'(num_pages - 2*num_queues);
            // Pages above the reset layout start free, entries past them are don't-care
            for (int i = 0; i < num_pages; i++) begin
                free_list[i]  <= page_t'(2*num_queues + i);
                link_table[i] <= '0;
            end
            // Each queue starts on page 2q with 2q+1 preallocated
            for (int q = 0; q < num_queues; q++) begin
                link_table[2*q] <= page_t'(2*q + 1);
            end
        end else begin
            if (alloc_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop may meet in one cycle
            if (page_free) begin
                free_list[wr_ptr] <= page_free_num;
                wr_ptr            <= wr_ptr + 1'b1;
            end
            if (link_wr) begin
                link_table[link_page] <= link_next;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/enqueue_controller.sv ====
/* Tail tracking per queue. Packets of different queues may interleave
   only at packet boundaries; input words are always taken. */
`timescale 1ns/1ps
`default_nettype none

module enqueue_controller (
    input  wire                       packet_in,
    input  wire                       rst,
    input  wire queue_pkg::in_word_t  word_in,
    input  wire                       word_in_valid,
    output queue_pkg::enq_word_t      enq_word,
    output logic                      enq_valid,
    output queue_pkg::queue_id_t      enq_count_queue,
    output logic                      enq_count_valid,
    output logic                      alloc_pop,
    input  wire queue_pkg::page_t     alloc_page,
    output logic                      link_wr,
    output queue_pkg::page_t          link_page,
    output queue_pkg::page_t          link_next
);

    import queue_pkg::*;

    enq_meta_t tail [num_queues];
    enq_meta_t cur_tail;
    logic      wrap;

    assign cur_tail = tail[word_in.queue_id];
    assign wrap     = word_in_valid
                      && cur_tail.tail_offset == offset_t'(words_per_page - 1);

    // Pop in the same cycle the page is taken
    // so a wrap on the very next word sees a fresh head
    assign alloc_pop = wrap;

    //////////////////////////////////////////////////////////////////////
    // Tail records

    always_ff @(posedge packet_in) begin
        if (rst) begin
            enq_valid       <= 1'b0;
            enq_count_valid <= 1'b0;
            link_wr         <= 1'b0;
            for (int q = 0; q < num_queues; q++) begin
                tail[q] <= '{cur_page:    page_t'(2*q),
                             next_page:   page_t'(2*q + 1),
                             tail_offset: '0};
            end
        end else begin
            enq_valid       <= word_in_valid;
            enq_count_valid <= word_in_valid;
            link_wr         <= wrap;
            if (word_in_valid) begin
                tail[word_in.queue_id].tail_offset <= cur_tail.tail_offset + 1'b1;
                // Step onto the preallocated page and fetch a new one
                if (wrap) begin
                    tail[word_in.queue_id].cur_page  <= cur_tail.next_page;
                    tail[word_in.queue_id].next_page <= alloc_page;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Payload

    always_ff @(posedge packet_in) begin
        // Record before the advance, i.e. where this word goes
        enq_word        <= '{word: word_in, meta: cur_tail};
        enq_count_queue <= word_in.queue_id;
        // Chain the page we step onto to the one just popped
        link_page       <= cur_tail.next_page;
        link_next       <= alloc_page;
    end

endmodule

`default_nettype wire

// ==== design/queue_memory.sv ====
/* Shared word memory with a 2-stage write and 6-stage read path.
   No back-pressure; reads of a page's last offset report it drained. */
`timescale 1ns/1ps
`default_nettype none

module queue_memory (
    input  wire                         packet_in,
    input  wire                         rst,
    input  wire queue_pkg::enq_word_t   enq_word,
    input  wire                         enq_valid,
    input  wire queue_pkg::head_read_t  head_rd,
    input  wire                         head_rd_valid,
    output queue_pkg::out_word_t        word_out,
    output logic                        word_out_valid,
    output queue_pkg::deq_note_t        deq_note,
    output logic                        deq_note_valid,
    output logic                        page_free,
    output queue_pkg::page_t            page_free_num
);

    import queue_pkg::*;

    typedef struct packed {
        keep_code_t code;
        logic       last;
    } meta_entry_t;

    // Keep is contiguous from byte 0, so the first clear bit is the count
    function automatic keep_code_t encode_keep(input keep_t keep);
        for (int i = 1; i < data_bytes; i++) begin
            if (!keep[i]) begin
                return keep_code_t'(i);
            end
        end
        return '0;
    endfunction

    function automatic keep_t decode_keep(input keep_code_t code);
        keep_t keep;
        keep = '0;
        for (int i = 0; i < data_bytes; i++) begin
            keep[i] = (code == '0) || (i < code);
        end
        return keep;
    endfunction

    function automatic byte_count_t byte_count(input keep_code_t code);
        return (code == '0) ? byte_count_t'(data_bytes) : byte_count_t'(code);
    endfunction

    data_t       data_mem [num_pages*words_per_page];
    meta_entry_t meta_mem [num_pages*words_per_page];

    // Write side
    logic        sop;
    logic        wr_en;
    mem_addr_t   wr_addr;
    data_t       wr_data;
    meta_entry_t wr_meta;
    page_t       wr_page;
    offset_t     wr_offset;
    page_t       wr_page_now;
    offset_t     wr_offset_now;

    // Read side, index is the stage number
    logic [5:2]  rd_vld;
    head_read_t  rd_head;
    mem_addr_t   rd_addr;
    queue_id_t   rd_queue [5:3];
    data_t       data_do;
    data_t       data_res;
    data_t       data_dec;
    meta_entry_t meta_do;
    meta_entry_t meta_res;
    keep_t       keep_dec;
    byte_count_t bytes_dec;
    logic        last_dec;
    port_t       port_dec;

    // First word of a packet starts at the tail record, later ones follow on
    assign wr_page_now   = sop ? enq_word.meta.cur_page : wr_page;
    assign wr_offset_now = sop ? enq_word.meta.tail_offset : wr_offset;

    assign rd_addr  = {rd_head.head_page, rd_head.head_offset};
    assign port_dec = port_t'(rd_queue[5] >> $clog2(queues_per_port));

    //////////////////////////////////////////////////////////////////////
    // Control

    always_ff @(posedge packet_in) begin
        if (rst) begin
            sop            <= 1'b1;
            wr_en          <= 1'b0;
            rd_vld         <= '0;
            page_free      <= 1'b0;
            word_out_valid <= 1'b0;
            deq_note_valid <= 1'b0;
        end else begin
            wr_en <= enq_valid;
            if (enq_valid) begin
                sop <= enq_word.word.last;
            end
            rd_vld         <= {rd_vld[4:2], head_rd_valid};
            page_free      <= rd_vld[2] && rd_head.head_offset == offset_t'(words_per_page - 1);
            word_out_valid <= rd_vld[5];
            deq_note_valid <= rd_vld[5];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Enqueue write

    always_ff @(posedge packet_in) begin
        // Stage 1
        wr_data <= enq_word.word.data;
        wr_meta <= '{code: encode_keep(enq_word.word.keep), last: enq_word.word.last};
        if (enq_valid) begin
            wr_addr   <= {wr_page_now, wr_offset_now};
            wr_offset <= wr_offset_now + 1'b1;
            // At the page end move to the page the producer linked in
            wr_page   <= (wr_offset_now == offset_t'(words_per_page - 1))
                         ? enq_word.meta.next_page : wr_page_now;
        end
        // Stage 2
        if (wr_en) begin
            data_mem[wr_addr] <= wr_data;
            meta_mem[wr_addr] <= wr_meta;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Dequeue read

    always_ff @(posedge packet_in) begin
        // Stage 2 address
        rd_head     <= head_rd;
        // Stage 3 memory read
        data_do     <= data_mem[rd_addr];
        meta_do     <= meta_mem[rd_addr];
        rd_queue[3] <= rd_head.queue_id;
        page_free_num <= rd_head.head_page;
        // Stage 4 output register
        data_res    <= data_do;
        meta_res    <= meta_do;
        rd_queue[4] <= rd_queue[3];
        // Stage 5 decode
        data_dec    <= data_res;
        keep_dec    <= decode_keep(meta_res.code);
        bytes_dec   <= byte_count(meta_res.code);
        last_dec    <= meta_res.last;
        rd_queue[5] <= rd_queue[4];
        // Stage 6
        word_out    <= '{data: data_dec, keep: keep_dec, last: last_dec, port: port_dec};
        deq_note    <= '{queue_id: rd_queue[5], byte_count: bytes_dec, last: last_dec};
    end

endmodule

`default_nettype wire

// ==== design/dequeue_controller.sv ====
/* Head pointers and word counts per queue. Requests for empty queues are
   dropped; an accepted request reads one word. */
`timescale 1ns/1ps
`default_nettype none

module dequeue_controller (
    input  wire                        packet_in,
    input  wire                        rst,
    input  wire                        deq_req,
    input  wire queue_pkg::queue_id_t  deq_queue,
    input  wire                        enq_count_valid,
    input  wire queue_pkg::queue_id_t  enq_count_queue,
    output queue_pkg::head_read_t      head_rd,
    output logic                       head_rd_valid,
    output queue_pkg::page_t           link_rd_page,
    input  wire queue_pkg::page_t      link_of
);

    import queue_pkg::*;

    count_t  count [num_queues];
    page_t   head_page [num_queues];
    offset_t head_offset [num_queues];
    offset_t offset_now;
    logic    accept;

    assign accept       = deq_req && count[deq_queue] != '0;
    assign offset_now   = head_offset[deq_queue];
    // Link table is read combinationally for the queue asked about
    assign link_rd_page = head_page[deq_queue];

    //////////////////////////////////////////////////////////////////////
    // Counts and head pointers

    always_ff @(posedge packet_in) begin
        if (rst) begin
            head_rd_valid <= 1'b0;
            for (int q = 0; q < num_queues; q++) begin
                count[q]       <= '0;
                head_page[q]   <= page_t'(2*q);
                head_offset[q] <= '0;
            end
        end else begin
            head_rd_valid <= accept;
            // Increment and decrement may hit the same queue
            for (int q = 0; q < num_queues; q++) begin
                count[q] <= count[q]
                            + count_t'(enq_count_valid && enq_count_queue == queue_id_t'(q))
                            - count_t'(accept && deq_queue == queue_id_t'(q));
            end
            if (accept) begin
                head_offset[deq_queue] <= offset_now + 1'b1;
                // Leaving the last word of a page
                if (offset_now == offset_t'(words_per_page - 1)) begin
                    head_page[deq_queue] <= link_of;
                end
            end
        end
    end

    // Old head goes out, the advance above takes effect together with it
    always_ff @(posedge packet_in) begin
        head_rd <= '{queue_id:    deq_queue,
                     head_page:   link_rd_page,
                     head_offset: offset_now};
    end

endmodule

`default_nettype wire

// ==== design/queue_subsystem.sv ====
/* Packet queue top level. No back-pressure anywhere; the user must keep
   the stored words below the page capacity. */
`timescale 1ns/1ps
`default_nettype none

module queue_subsystem (
    input  wire                        packet_in,
    input  wire                        rst,
    input  wire queue_pkg::in_word_t   word_in,
    input  wire                        word_in_valid,
    input  wire                        deq_req,
    input  wire queue_pkg::queue_id_t  deq_queue,
    output queue_pkg::out_word_t       word_out,
    output logic                       word_out_valid,
    output queue_pkg::deq_note_t       deq_note,
    output logic                       deq_note_valid
);

    import queue_pkg::*;

    // Producer to buffer and consumer
    enq_word_t  enq_word;
    logic       enq_valid;
    queue_id_t  enq_count_queue;
    logic       enq_count_valid;

    // Free list and links
    logic       alloc_pop;
    page_t      alloc_page;
    logic       link_wr;
    page_t      link_page;
    page_t      link_next;
    page_t      link_rd_page;
    page_t      link_of;
    logic       page_free;
    page_t      page_free_num;

    // Consumer to buffer
    head_read_t head_rd;
    logic       head_rd_valid;

    enqueue_controller u_enqueue (
        .packet_in       (packet_in),
        .rst             (rst),
        .word_in         (word_in),
        .word_in_valid   (word_in_valid),
        .enq_word        (enq_word),
        .enq_valid       (enq_valid),
        .enq_count_queue (enq_count_queue),
        .enq_count_valid (enq_count_valid),
        .alloc_pop       (alloc_pop),
        .alloc_page      (alloc_page),
        .link_wr         (link_wr),
        .link_page       (link_page),
        .link_next       (link_next)
    );

    page_allocator u_allocator (
        .packet_in     (packet_in),
        .rst           (rst),
        .alloc_pop     (alloc_pop),
        .alloc_page    (alloc_page),
        .page_free     (page_free),
        .page_free_num (page_free_num),
        .link_wr       (link_wr),
        .link_page     (link_page),
        .link_next     (link_next),
        .link_rd_page  (link_rd_page),
        .link_of       (link_of)
    );

    dequeue_controller u_dequeue (
        .packet_in       (packet_in),
        .rst             (rst),
        .deq_req         (deq_req),
        .deq_queue       (deq_queue),
        .enq_count_valid (enq_count_valid),
        .enq_count_queue (enq_count_queue),
        .head_rd         (head_rd),
        .head_rd_valid   (head_rd_valid),
        .link_rd_page    (link_rd_page),
        .link_of         (link_of)
    );

    queue_memory u_memory (
        .packet_in      (packet_in),
        .rst            (rst),
        .enq_word       (enq_word),
        .enq_valid      (enq_valid),
        .head_rd        (head_rd),
        .head_rd_valid  (head_rd_valid),
        .word_out       (word_out),
        .word_out_valid (word_out_valid),
        .deq_note       (deq_note),
        .deq_note_valid (deq_note_valid),
        .page_free      (page_free),
        .page_free_num  (page_free_num)
    );

endmodule

`default_nettype wire

// ==== tests/queue_subsystem_tb.sv ====
/* Random packets and dequeues checked against a word queue model. Stored
   words are held low enough that the page pool never runs out. */
`timescale 1ns/1ps
`default_nettype none

module queue_subsystem_tb;

    import queue_pkg::*;

    localparam int run_cycles    = 3000;
    localparam int stored_limit  = 10;
    localparam int drain_timeout = 500;
    localparam int pipe_depth    = 6;
    // Cycles before a driven word may be requested
    localparam int ready_delay   = 4;

    typedef struct packed {
        logic [31:0] born;
        queue_id_t   queue_id;
        data_t       data;
        keep_t       keep;
        logic        last;
    } model_word_t;

    logic      packet_in;
    logic      rst;
    in_word_t  word_in;
    logic      word_in_valid;
    logic      deq_req;
    queue_id_t deq_queue;
    out_word_t word_out;
    logic      word_out_valid;
    deq_note_t deq_note;
    logic      deq_note_valid;

    logic [31:0] rng_state;
    int          cycle;
    int          pkt_left;
    queue_id_t   pkt_queue;
    int          drain_wait;

    // All queues share one list, the first entry of a queue id is its head
    model_word_t model_q [$];
    // Slot 0 is this cycle's request, the last slot is due at the output
    model_word_t pipe_word [pipe_depth];
    logic        pipe_valid [pipe_depth];

    queue_subsystem uut (
        .packet_in      (packet_in),
        .rst            (rst),
        .word_in        (word_in),
        .word_in_valid  (word_in_valid),
        .deq_req        (deq_req),
        .deq_queue      (deq_queue),
        .word_out       (word_out),
        .word_out_valid (word_out_valid),
        .deq_note       (deq_note),
        .deq_note_valid (deq_note_valid)
    );

    initial begin
        packet_in = 1'b0;
        forever #50 packet_in = ~packet_in;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    // Lowest n bytes enabled
    function automatic keep_t keep_for_bytes(input int n);
        keep_t keep;
        for (int i = 0; i < data_bytes; i++) begin
            keep[i] = (i < n);
        end
        return keep;
    endfunction

    function automatic int find_front(input queue_id_t q);
        for (int i = 0; i < model_q.size(); i++) begin
            if (model_q[i].queue_id == q) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic check_outputs();
        model_word_t w;
        w = pipe_word[pipe_depth-1];
        check("word_out_valid", pipe_valid[pipe_depth-1], word_out_valid);
        check("deq_note_valid", pipe_valid[pipe_depth-1], deq_note_valid);
        if (pipe_valid[pipe_depth-1]) begin
            check("word_out data", w.data, word_out.data);
            check("word_out keep", w.keep, word_out.keep);
            check("word_out last", w.last, word_out.last);
            // Egress port is the high bit of the queue id
            check("word_out port", w.queue_id[1], word_out.port);
            check("deq_note queue_id", w.queue_id, deq_note.queue_id);
            check("deq_note byte_count", $countones(w.keep), deq_note.byte_count);
            check("deq_note last", w.last, deq_note.last);
        end
    endtask

    // Step to 1 ns after the next edge, check outputs and advance the pipeline
    task automatic next_cycle();
        @(posedge packet_in);
        #1;
        cycle++;
        check_outputs();
        for (int i = pipe_depth - 1; i > 0; i--) begin
            pipe_word[i]  = pipe_word[i-1];
            pipe_valid[i] = pipe_valid[i-1];
        end
        pipe_valid[0] = 1'b0;
        deq_req       = 1'b0;
        word_in_valid = 1'b0;
    endtask

    // Requests only where the model knows the outcome
    task automatic issue_request(input queue_id_t q);
        int idx;
        idx = find_front(q);
        if (idx < 0) begin
            // Empty queue, the request must be dropped
            deq_req   = 1'b1;
            deq_queue = q;
        end else if (model_q[idx].born + ready_delay <= cycle) begin
            deq_req       = 1'b1;
            deq_queue     = q;
            pipe_word[0]  = model_q[idx];
            pipe_valid[0] = 1'b1;
            model_q.delete(idx);
        end
    endtask

    task automatic drive_word();
        in_word_t    w;
        model_word_t m;
        int          nbytes;
        if (pkt_left == 0 && model_q.size() <= stored_limit && next_rand() % 4 != 0) begin
            pkt_left  = 1 + next_rand() % 6;
            pkt_queue = queue_id_t'(next_rand() % num_queues);
        end
        if (pkt_left > 0 && next_rand() % 4 != 0) begin
            w.data     = {next_rand(), next_rand()};
            w.last     = (pkt_left == 1);
            nbytes     = w.last ? 1 + next_rand() % data_bytes : data_bytes;
            w.keep     = keep_for_bytes(nbytes);
            w.queue_id = pkt_queue;
            word_in       = w;
            word_in_valid = 1'b1;
            m = '{born: cycle, queue_id: w.queue_id, data: w.data, keep: w.keep, last: w.last};
            model_q.push_back(m);
            pkt_left--;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        word_in       = '0;
        word_in_valid = 1'b0;
        deq_req       = 1'b0;
        deq_queue     = '0;
        rst           = 1'b1;
        rng_state     = 32'h9c3f_1a5d;
        cycle         = 0;
        pkt_left      = 0;
        pkt_queue     = '0;
        drain_wait    = 0;
        for (int i = 0; i < pipe_depth; i++) begin
            pipe_valid[i] = 1'b0;
            pipe_word[i]  = '0;
        end
        repeat (3) @(posedge packet_in);
        #1;
        rst = 1'b0;

        // Request first so a word driven this cycle is not yet visible
        for (int n = 0; n < run_cycles; n++) begin
            next_cycle();
            if (next_rand() % 4 != 0) begin
                issue_request(queue_id_t'(next_rand() % num_queues));
            end
            drive_word();
        end

        // Drain every queue, oldest word first
        while (model_q.size() != 0) begin
            if (drain_wait >= drain_timeout) begin
                $display("Timeout: %0d words still stored after the drain phase",
                         model_q.size());
                $display("Test FAILED");
                $fatal(1, "Drain timeout");
            end else begin
                next_cycle();
                issue_request(model_q[0].queue_id);
                drain_wait++;
            end
        end
        repeat (pipe_depth) next_cycle();

        // Every queue must now read as empty
        for (int q = 0; q < num_queues; q++) begin
            next_cycle();
            issue_request(queue_id_t'(q));
        end
        repeat (pipe_depth) next_cycle();

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
design/queue_pkg.sv
design/page_allocator.sv
design/enqueue_controller.sv
design/queue_memory.sv
design/dequeue_controller.sv
design/queue_subsystem.sv
tests/queue_subsystem_tb.sv
